// File: src/md_defs.svh
`ifndef MD_DEFS_SVH
`define MD_DEFS_SVH

// datapath widths
`define MD_XLEN        32
`define MD_MUL_XLEN    34   // multiplier after sign or zero extension

// booth array
`define MD_BOOTH_ROWS  4    // digits retired per cycle
`define MD_MUL_CYCLES  5    // 17 digits over 4 rows

// divider
`define MD_DIV_CYCLES  16   // two quotient bits per step

`define MD_CNT_W       5

// request op field
`define MD_OP_MUL      1'b0
`define MD_OP_DIV      1'b1

// result half select
`define MD_OUT_LO      1'b0
`define MD_OUT_HI      1'b1

`endif

// File: src/md_pkg.sv
`default_nettype none

`include "md_defs.svh"

package md_pkg;

   typedef struct packed {
      logic                op;            // MD_OP_MUL or MD_OP_DIV
      logic                in_1_signed;
      logic                in_2_signed;
      logic                out_sel;       // MD_OUT_LO or MD_OUT_HI
      logic [`MD_XLEN-1:0] in_1;
      logic [`MD_XLEN-1:0] in_2;
   } md_req_t;

   // one booth row, pp + neg is the signed multiple
   typedef struct packed {
      logic [`MD_MUL_XLEN-1:0] pp;
      logic                    neg;
   } booth_pp_t;

   typedef struct packed {
      logic [`MD_XLEN-1:0] hi;
      logic [`MD_XLEN-1:0] lo;
   } md_product_t;

   typedef struct packed {
      logic [`MD_XLEN-1:0] rem;
      logic [`MD_XLEN-1:0] quo;
   } md_division_t;

   // 64-bit result word, read as a product or as rem/quo
   typedef union packed {
      md_product_t  product;
      md_division_t division;
   } md_result_u;

endpackage

`default_nettype wire

// File: src/md_sequencer.sv
`default_nettype none

`include "md_defs.svh"

module md_sequencer (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      req_valid,
   input  md_pkg::md_req_t           req,
   output logic                      req_ready,
   output logic                      resp_valid,
   output logic                      op,
   output logic                      out_sel,
   output logic                      mul_active,
   output logic [`MD_XLEN-1:0]       multiplicand,
   output logic                      mul_signed,
   output logic [`MD_MUL_XLEN-1:0]   multiplier,
   output logic                      div_start,
   output logic                      div_step,
   output logic                      div_by_zero
);

   localparam int SHIFT = 2 * `MD_BOOTH_ROWS;

   logic [`MD_CNT_W-1:0]     cnt_q;
   logic                     busy;
   logic                     accept;
   logic                     dbz_q;
   logic                     divisor_zero;
   logic [`MD_MUL_XLEN-1:0]  mul_next;

   assign busy         = (cnt_q != '0);
   assign req_ready    = ~busy;
   assign accept       = req_valid & req_ready;
   assign divisor_zero = (req.in_2 == '0);

   assign div_start    = accept & (req.op == `MD_OP_DIV);
   assign mul_active   = busy & (op == `MD_OP_MUL);
   assign div_step     = (op == `MD_OP_DIV) & (cnt_q > `MD_CNT_W'd1);   // last count is fixup
   assign div_by_zero  = busy & dbz_q;

   // drop one chunk and carry its top bit into the rest, so the low
   // window can always recode with a zero below bit 0
   assign mul_next = {{SHIFT{multiplier[`MD_MUL_XLEN-1]}}, multiplier[`MD_MUL_XLEN-1:SHIFT]}
                     + `MD_MUL_XLEN'(multiplier[SHIFT-1]);

   always_ff @(posedge clk) begin
      if (reset) begin
         cnt_q      <= '0;
         resp_valid <= 1'b0;
         op         <= `MD_OP_MUL;
         dbz_q      <= 1'b0;
      end else begin
         resp_valid <= 1'b0;
         if (accept) begin
            op    <= req.op;
            dbz_q <= (req.op == `MD_OP_DIV) & divisor_zero;
            if (req.op == `MD_OP_MUL) begin
               cnt_q <= `MD_CNT_W'(`MD_MUL_CYCLES);
            end else if (divisor_zero) begin
               cnt_q <= `MD_CNT_W'd1;   // straight to the result
            end else begin
               cnt_q <= `MD_CNT_W'(`MD_DIV_CYCLES + 1);
            end
         end else if (busy) begin
            cnt_q <= cnt_q - `MD_CNT_W'd1;
            if (cnt_q == `MD_CNT_W'd1) begin
               resp_valid <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         out_sel      <= req.out_sel;
         multiplicand <= req.in_2;
         mul_signed   <= req.in_2_signed;
         multiplier   <= {{(`MD_MUL_XLEN - `MD_XLEN){req.in_1_signed & req.in_1[`MD_XLEN-1]}},
                          req.in_1};
      end else if (mul_active) begin
         multiplier   <= mul_next;
      end
   end

endmodule

`default_nettype wire

// File: src/booth_row.sv
`default_nettype none

`include "md_defs.svh"

module booth_row (
   input  logic [2:0]           window,
   input  logic [`MD_XLEN-1:0]  multiplicand,
   input  logic                 mul_signed,
   output md_pkg::booth_pp_t    row_pp
);

   logic                     ext;
   logic                     neg;
   logic [`MD_MUL_XLEN-1:0]  one_x;
   logic [`MD_MUL_XLEN-1:0]  two_x;
   logic [`MD_MUL_XLEN-1:0]  mag;

   assign ext   = mul_signed & multiplicand[`MD_XLEN-1];
   assign one_x = {{(`MD_MUL_XLEN - `MD_XLEN){ext}}, multiplicand};
   assign two_x = {ext, multiplicand, 1'b0};

   // digit magnitude from the window
   always_comb begin
      case (window)
         3'b001, 3'b010, 3'b101, 3'b110: mag = one_x;
         3'b011, 3'b100:                 mag = two_x;
         default:                        mag = '0;   // 000 and 111 are zero
      endcase
   end

   assign neg = window[2] & ~(window[1] & window[0]);

   assign row_pp.pp  = neg ? ~mag : mag;
   assign row_pp.neg = neg;   // plus one added by the accumulator

endmodule

`default_nettype wire

// File: src/pp_accumulator.sv
`default_nettype none

`include "md_defs.svh"

module pp_accumulator (
   input  logic                                         clk,
   input  logic                                         reset,
   input  logic                                         mul_start,
   input  logic                                         mul_active,
   input  md_pkg::booth_pp_t [`MD_BOOTH_ROWS-1:0]       rows,
   output md_pkg::md_result_u                           product
);

   localparam int ACC_W = 42;                             // one cycle's sum plus running part
   localparam int SHIFT = 2 * `MD_BOOTH_ROWS;
   localparam int UP_W  = ACC_W - SHIFT;
   localparam int LOW_W = `MD_MUL_CYCLES * SHIFT;         // finished bits after the last cycle

   logic [UP_W-1:0]   upper_q;                            // running sum above the done bits
   logic [LOW_W-1:0]  lower_q;
   logic [ACC_W-1:0]  row_w [`MD_BOOTH_ROWS];
   logic [ACC_W-1:0]  neg_w;
   logic [ACC_W-1:0]  run_w;
   logic [ACC_W-1:0]  s_a, c_a;
   logic [ACC_W-1:0]  s_b, c_b;
   logic [ACC_W-1:0]  s_c, c_c;
   logic [ACC_W-1:0]  s_d, c_d;
   logic [ACC_W-1:0]  total;

   function automatic void csa(
      input  logic [ACC_W-1:0] a,
      input  logic [ACC_W-1:0] b,
      input  logic [ACC_W-1:0] c,
      output logic [ACC_W-1:0] s,
      output logic [ACC_W-1:0] cy
   );
      s  = a ^ b ^ c;
      cy = ((a & b) | (b & c) | (a & c)) << 1;
   endfunction

   always_comb begin
      neg_w = '0;
      for (int k = 0; k < `MD_BOOTH_ROWS; k++) begin
         row_w[k] = {{(ACC_W - `MD_MUL_XLEN){rows[k].pp[`MD_MUL_XLEN-1]}}, rows[k].pp}
                    << (2 * k);
         neg_w[2 * k] = rows[k].neg;
      end
      run_w = {{(ACC_W - UP_W){upper_q[UP_W-1]}}, upper_q};

      // six operands down to two
      csa(row_w[0], row_w[1], row_w[2], s_a, c_a);
      csa(row_w[3], run_w, neg_w, s_b, c_b);
      csa(s_a, c_a, s_b, s_c, c_c);
      csa(s_c, c_c, c_b, s_d, c_d);
   end

   assign total = s_d + c_d;

   always_ff @(posedge clk) begin
      if (reset || mul_start) begin
         upper_q <= '0;
         lower_q <= '0;
      end else if (mul_active) begin
         upper_q <= total[ACC_W-1:SHIFT];
         lower_q <= {total[SHIFT-1:0], lower_q[LOW_W-1:SHIFT]};   // low byte is final
      end
   end

   assign product = {upper_q[63-LOW_W:0], lower_q};

endmodule

`default_nettype wire

// File: src/div_core.sv
`default_nettype none

`include "md_defs.svh"

module div_core (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  div_start,
   input  logic                  div_step,
   input  logic                  div_by_zero,
   input  logic [`MD_XLEN-1:0]   dividend,
   input  logic [`MD_XLEN-1:0]   divisor,
   input  logic                  is_signed,
   output md_pkg::md_result_u    quotient_rem
);

   // rem holds the partial remainder, quo shifts dividend out and quotient in
   md_pkg::md_result_u    res_q;
   logic [`MD_XLEN-1:0]   dvs_q;
   logic [`MD_XLEN+1:0]   dvs3_q;
   logic                  rem_neg_q;
   logic                  quo_neg_q;
   logic                  step_q;
   logic                  dividend_neg;
   logic                  divisor_neg;
   logic [`MD_XLEN-1:0]   dvs_mag;
   logic [`MD_XLEN+1:0]   r_shift;
   logic [`MD_XLEN+2:0]   d1;
   logic [`MD_XLEN+2:0]   d2;
   logic [`MD_XLEN+2:0]   d3;
   logic [1:0]            q_digit;
   logic [`MD_XLEN-1:0]   r_next;
   logic                  fixup;

   assign dividend_neg = is_signed & dividend[`MD_XLEN-1];
   assign divisor_neg  = is_signed & divisor[`MD_XLEN-1];   // first flag covers both
   assign dvs_mag      = divisor_neg ? -divisor : divisor;

   assign fixup = step_q & ~div_step;   // cycle after the last step

   // three trial differences side by side
   assign r_shift = {res_q.division.rem, res_q.division.quo[`MD_XLEN-1:`MD_XLEN-2]};
   assign d1      = {1'b0, r_shift} - {3'b000, dvs_q};
   assign d2      = {1'b0, r_shift} - {2'b00, dvs_q, 1'b0};
   assign d3      = {1'b0, r_shift} - {1'b0, dvs3_q};

   always_comb begin
      if (!d3[`MD_XLEN+2]) begin
         q_digit = 2'd3;
         r_next  = d3[`MD_XLEN-1:0];
      end else if (!d2[`MD_XLEN+2]) begin
         q_digit = 2'd2;
         r_next  = d2[`MD_XLEN-1:0];
      end else if (!d1[`MD_XLEN+2]) begin
         q_digit = 2'd1;
         r_next  = d1[`MD_XLEN-1:0];
      end else begin
         q_digit = 2'd0;
         r_next  = r_shift[`MD_XLEN-1:0];
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         step_q <= 1'b0;
      end else begin
         step_q <= div_step;
      end
   end

   always_ff @(posedge clk) begin
      if (div_start) begin
         res_q.division.rem <= '0;
         res_q.division.quo <= dividend_neg ? -dividend : dividend;
         dvs_q              <= dvs_mag;
         dvs3_q             <= {2'b00, dvs_mag} + {1'b0, dvs_mag, 1'b0};
         rem_neg_q          <= dividend_neg;
         quo_neg_q          <= dividend_neg ^ divisor_neg;
      end else if (div_by_zero) begin
         // quo still holds the dividend magnitude here
         res_q.division.rem <= rem_neg_q ? -res_q.division.quo : res_q.division.quo;
         res_q.division.quo <= '1;
      end else if (div_step) begin
         res_q.division.rem <= r_next;
         res_q.division.quo <= {res_q.division.quo[`MD_XLEN-3:0], q_digit};
      end else if (fixup) begin
         // min / -1 comes out of the magnitudes as min rem 0
         res_q.division.rem <= rem_neg_q ? -res_q.division.rem : res_q.division.rem;
         res_q.division.quo <= quo_neg_q ? -res_q.division.quo : res_q.division.quo;
      end
   end

   assign quotient_rem = res_q;

endmodule

`default_nettype wire

// File: src/mul_div_unit.sv
`default_nettype none

`include "md_defs.svh"

module mul_div_unit (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  req_valid,
   input  md_pkg::md_req_t       req,
   output logic                  req_ready,
   output logic                  resp_valid,
   output logic [`MD_XLEN-1:0]   resp_result
);

   logic                                      op;
   logic                                      out_sel;
   logic                                      mul_active;
   logic                                      mul_start;
   logic [`MD_XLEN-1:0]                       multiplicand;
   logic                                      mul_signed;
   logic [`MD_MUL_XLEN-1:0]                   multiplier;
   logic                                      div_start;
   logic                                      div_step;
   logic                                      div_by_zero;
   md_pkg::booth_pp_t [`MD_BOOTH_ROWS-1:0]    rows;
   md_pkg::md_result_u                        mul_res;
   md_pkg::md_result_u                        div_res;

   assign mul_start = req_valid & req_ready & (req.op == `MD_OP_MUL);

   md_sequencer u_seq (
      .clk          (clk),
      .reset        (reset),
      .req_valid    (req_valid),
      .req          (req),
      .req_ready    (req_ready),
      .resp_valid   (resp_valid),
      .op           (op),
      .out_sel      (out_sel),
      .mul_active   (mul_active),
      .multiplicand (multiplicand),
      .mul_signed   (mul_signed),
      .multiplier   (multiplier),
      .div_start    (div_start),
      .div_step     (div_step),
      .div_by_zero  (div_by_zero)
   );

   for (genvar k = 0; k < `MD_BOOTH_ROWS; k++) begin : g_row
      logic [2:0] window;
      if (k == 0) begin : g_first
         assign window = {multiplier[1:0], 1'b0};
      end else begin : g_rest
         assign window = multiplier[2*k+1:2*k-1];
      end
      booth_row u_row (
         .window       (window),
         .multiplicand (multiplicand),
         .mul_signed   (mul_signed),
         .row_pp       (rows[k])
      );
   end

   pp_accumulator u_acc (
      .clk        (clk),
      .reset      (reset),
      .mul_start  (mul_start),
      .mul_active (mul_active),
      .rows       (rows),
      .product    (mul_res)
   );

   div_core u_div (
      .clk          (clk),
      .reset        (reset),
      .div_start    (div_start),
      .div_step     (div_step),
      .div_by_zero  (div_by_zero),
      .dividend     (req.in_1),
      .divisor      (req.in_2),
      .is_signed    (req.in_1_signed),
      .quotient_rem (div_res)
   );

   always_comb begin
      if (op == `MD_OP_DIV) begin
         resp_result = (out_sel == `MD_OUT_HI) ? div_res.division.rem : div_res.division.quo;
      end else begin
         resp_result = (out_sel == `MD_OUT_HI) ? mul_res.product.hi : mul_res.product.lo;
      end
   end

endmodule

`default_nettype wire

// File: bench/mul_div_assert.sv
`default_nettype none

`include "md_defs.svh"

module mul_div_assert (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  req_valid,
   input  md_pkg::md_req_t       req,
   input  logic                  req_ready,
   input  logic                  resp_valid,
   input  logic [`MD_XLEN-1:0]   resp_result
);

   timeunit 1ns;
   timeprecision 100ps;

   int                   errors = 0;
   logic                 accept;
   logic                 is_mul;
   logic                 div_zero;
   logic                 pending_q;   // accepted, response not yet seen
   logic [`MD_XLEN-1:0]  exp_q;

   assign accept   = req_valid & req_ready;
   assign is_mul   = (req.op == `MD_OP_MUL);
   assign div_zero = (req.in_2 == '0);

   // 64-bit reference for one request
   function automatic logic [`MD_XLEN-1:0] expected_result(input md_pkg::md_req_t r);
      logic signed [63:0]   a;
      logic signed [63:0]   b;
      logic signed [63:0]   prod;
      logic signed [63:0]   quo;
      logic signed [63:0]   rem;
      logic [`MD_XLEN-1:0]  res;
      a = {{32{r.in_1_signed & r.in_1[31]}}, r.in_1};
      if (r.op == `MD_OP_MUL) begin
         b    = {{32{r.in_2_signed & r.in_2[31]}}, r.in_2};
         prod = a * b;
         res  = (r.out_sel == `MD_OUT_HI) ? prod[63:32] : prod[31:0];
      end else begin
         b = {{32{r.in_1_signed & r.in_2[31]}}, r.in_2};   // divisor follows the first flag
         if (b == 0) begin
            quo = '1;
            rem = a;
         end else if (r.in_1_signed && r.in_1 == 32'h8000_0000 && r.in_2 == 32'hffff_ffff) begin
            quo = a;
            rem = '0;
         end else begin
            quo = a / b;   // truncates toward zero
            rem = a % b;
         end
         res = (r.out_sel == `MD_OUT_HI) ? rem[31:0] : quo[31:0];
      end
      return res;
   endfunction

   always_ff @(posedge clk) begin
      if (reset) begin
         pending_q <= 1'b0;
      end else if (accept) begin
         pending_q <= 1'b1;
      end else if (resp_valid) begin
         pending_q <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         exp_q <= expected_result(req);
      end
   end

   idle_after_reset: assert property (@(posedge clk) reset |=> (req_ready && !resp_valid))
      else begin
         errors++;
         $error("unit not idle after reset");
      end

   mul_latency: assert property (@(posedge clk) disable iff (reset)
      accept && is_mul |=> !resp_valid [*5] ##1 resp_valid)
      else begin
         errors++;
         $error("multiply response pulse missing or not at the sixth edge");
      end

   div_latency: assert property (@(posedge clk) disable iff (reset)
      accept && !is_mul && !div_zero |=> !resp_valid [*17] ##1 resp_valid)
      else begin
         errors++;
         $error("divide response pulse missing or not at the eighteenth edge");
      end

   div_zero_latency: assert property (@(posedge clk) disable iff (reset)
      accept && !is_mul && div_zero |=> !resp_valid ##1 resp_valid)
      else begin
         errors++;
         $error("zero divisor response pulse missing or not at the second edge");
      end

   result_value: assert property (@(posedge clk) disable iff (reset)
      resp_valid |-> (resp_result == exp_q))
      else begin
         errors++;
         $error("ERR %0t resp_result got %h expected %h",
                $time, $sampled(resp_result), $sampled(exp_q));
      end

   busy_not_ready: assert property (@(posedge clk) disable iff (reset)
      pending_q && !resp_valid |-> !req_ready)
      else begin
         errors++;
         $error("req_ready high while an operation is still running");
      end

   ready_at_resp: assert property (@(posedge clk) disable iff (reset)
      resp_valid |-> req_ready)
      else begin
         errors++;
         $error("req_ready low in the response cycle");
      end

   one_pulse: assert property (@(posedge clk) disable iff (reset)
      resp_valid |-> pending_q ##1 !resp_valid)
      else begin
         errors++;
         $error("response pulse without a pending request or longer than one cycle");
      end

endmodule

bind mul_div_unit mul_div_assert u_chk (
   .clk         (clk),
   .reset       (reset),
   .req_valid   (req_valid),
   .req         (req),
   .req_ready   (req_ready),
   .resp_valid  (resp_valid),
   .resp_result (resp_result)
);

`default_nettype wire

// File: bench/tb_mul_div.sv
`default_nettype none

`include "md_defs.svh"

module tb_mul_div;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int N_CORNER        = 5;
   localparam int N_DIRECTED      = N_CORNER * N_CORNER * 6;
   localparam int N_RANDOM        = 100;
   localparam int OP_CYCLES       = `MD_DIV_CYCLES + 4;   // slowest op plus hold and gaps
   localparam int WATCHDOG_CYCLES = (N_DIRECTED + N_RANDOM) * OP_CYCLES + 100;
   localparam int READY_LIMIT     = OP_CYCLES;
   localparam int RESP_LIMIT      = OP_CYCLES;

   logic                 clk;
   logic                 reset;
   logic                 req_valid;
   md_pkg::md_req_t      req;
   logic                 req_ready;
   logic                 resp_valid;
   logic [`MD_XLEN-1:0]  resp_result;

   int                   seed = 32'hc7d9_faeb;
   int                   tb_errors = 0;
   logic [`MD_XLEN-1:0]  corners [N_CORNER] = '{32'h0000_0000, 32'h0000_0001,
                                                32'hffff_ffff, 32'h8000_0000,
                                                32'h7fff_ffff};

   mul_div_unit dut0 (
      .clk         (clk),
      .reset       (reset),
      .req_valid   (req_valid),
      .req         (req),
      .req_ready   (req_ready),
      .resp_valid  (resp_valid),
      .resp_result (resp_result)
   );

   initial clk = 1'b0;
   always #4 clk = ~clk;

   function automatic md_pkg::md_req_t pack_request(input logic op, input logic s1,
                                                    input logic s2, input logic sel,
                                                    input logic [`MD_XLEN-1:0] a,
                                                    input logic [`MD_XLEN-1:0] b);
      md_pkg::md_req_t r;
      r.op          = op;
      r.in_1_signed = s1;
      r.in_2_signed = s2;
      r.out_sel     = sel;
      r.in_1        = a;
      r.in_2        = b;
      return r;
   endfunction

   // called 1 ns after an edge, returns at the same phase
   task automatic issue(input md_pkg::md_req_t r, input logic hold);
      int waited;
      waited = 0;
      while (!req_ready && waited < READY_LIMIT) begin
         @(posedge clk);
         #1;
         waited++;
      end
      if (!req_ready) begin
         tb_errors++;
         $display("%0t: unit stayed busy, request could not be sent", $time);
      end else begin
         req       = r;
         req_valid = 1'b1;
         @(posedge clk);
         #1;
         if (hold) begin
            req = md_pkg::md_req_t'(~r);   // must be ignored while busy
            @(posedge clk);
            #1;
         end
         req_valid = 1'b0;
         waited = 0;
         while (!resp_valid && waited < RESP_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
         end
         if (!resp_valid) begin
            tb_errors++;
            $display("%0t: no response pulse within %0d cycles", $time, RESP_LIMIT);
         end
      end
   endtask

   task automatic run_corners();
      int idx;
      for (int i = 0; i < N_CORNER; i++) begin
         for (int j = 0; j < N_CORNER; j++) begin
            idx = i * N_CORNER + j;
            for (int sel = 0; sel < 2; sel++) begin
               issue(pack_request(`MD_OP_MUL, idx[0], idx[1], sel[0], corners[i], corners[j]),
                     idx[2]);
               issue(pack_request(`MD_OP_DIV, 1'b0, idx[0], sel[0], corners[i], corners[j]),
                     1'b0);
               issue(pack_request(`MD_OP_DIV, 1'b1, idx[1], sel[0], corners[i], corners[j]),
                     idx[3]);
            end
         end
      end
   endtask

   task automatic run_random();
      logic [31:0]      rnd;
      md_pkg::md_req_t  r;
      for (int n = 0; n < N_RANDOM; n++) begin
         rnd = $random(seed);
         r   = pack_request(rnd[0], rnd[1], rnd[2], rnd[3], $random(seed), $random(seed));
         if (rnd[4]) begin
            r.in_2 = r.in_2 >> rnd[9:5];   // smaller divisors, zero now and then
         end
         issue(r, rnd[10]);
      end
   endtask

   initial begin
      reset     = 1'b1;
      req_valid = 1'b0;
      req       = '0;
      repeat (4) @(posedge clk);
      #1;
      reset = 1'b0;
      @(posedge clk);
      #1;
      run_corners();
      run_random();
      repeat (4) @(posedge clk);   // let the last result be checked
      $display("errors: %0d from assertions, %0d from bench", dut0.u_chk.errors, tb_errors);
      if (dut0.u_chk.errors == 0 && tb_errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
      $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: sim.f
+incdir+src
src/md_pkg.sv
src/md_sequencer.sv
src/booth_row.sv
src/pp_accumulator.sv
src/div_core.sv
src/mul_div_unit.sv
bench/mul_div_assert.sv
bench/tb_mul_div.sv
